//--- vlog.f
+incdir+bench
hw/mii_rx_pkg.sv
hw/udp_frame_pkg.sv
hw/mii_nibble_assembler.sv
hw/crc32_d8.sv
hw/payload_buffer.sv
hw/udp_header_parser.sv
hw/rx_mii_udp.sv
bench/tb_rx_mii_udp.sv

//--- Bender.yml
package:
  name: rx_mii_udp

sources:
  - hw/mii_rx_pkg.sv
  - hw/udp_frame_pkg.sv
  - hw/mii_nibble_assembler.sv
  - hw/crc32_d8.sv
  - hw/payload_buffer.sv
  - hw/udp_header_parser.sv
  - hw/rx_mii_udp.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_rx_mii_udp.sv

//--- bench/tb_frame_build.svh
`ifndef TB_FRAME_BUILD_SVH
`define TB_FRAME_BUILD_SVH

// frame bytes from the destination mac through the fcs
mii_rx_pkg::byte_t frame_q[$];
// payload bytes of the frame in frame_q
mii_rx_pkg::byte_t pay_q[$];

// bitwise reflected crc-32 over frame_q, returns the fcs value
function automatic logic [31:0] ref_crc();
	logic [31:0] c;
	int i;
	int b;
	c = 32'hFFFF_FFFF;
	for (i = 0; i < frame_q.size(); i++)
	begin
		c = c ^ {24'h0, frame_q[i]};
		for (b = 0; b < 8; b++)
			c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
	end
	return ~c;
endfunction

// network byte order, n bytes taken from the low end of v
task automatic push_be(input logic [47:0] v, input int n);
	int i;
	for (i = n - 1; i >= 0; i--)
		frame_q.push_back(v[8*i +: 8]);
endtask

task automatic build_frame(input udp_frame_pkg::mac_t src_mac, input logic [15:0] eth_type,
	input logic [7:0] proto, input udp_frame_pkg::ip_t src_ip,
	input udp_frame_pkg::port_t src_port, input int pay_n, input bit bad_fcs);
	logic [31:0] fcs;
	mii_rx_pkg::byte_t b;
	int i;
	frame_q.delete();
	pay_q.delete();
	push_be(48'h02_00_5E_10_00_01, 6);
	push_be(src_mac, 6);
	push_be(eth_type, 2);
	// ipv4 header, checksum left at zero
	push_be(8'h45, 1);
	push_be(8'h00, 1);
	push_be(16'(28 + pay_n), 2);
	push_be(16'h1234, 2);
	push_be(16'h4000, 2);
	push_be(8'h40, 1);
	push_be(proto, 1);
	push_be(16'h0000, 2);
	push_be(src_ip, 4);
	push_be(32'hC0A8_0001, 4);
	// udp header
	push_be(src_port, 2);
	push_be(16'h1F90, 2);
	push_be(16'(8 + pay_n), 2);
	push_be(16'h0000, 2);
	for (i = 0; i < pay_n; i++)
	begin
		b = mii_rx_pkg::byte_t'($urandom);
		pay_q.push_back(b);
		frame_q.push_back(b);
	end
	fcs = ref_crc();
	if (bad_fcs)
		fcs = fcs ^ 32'h0000_0100;
	// fcs goes out lsb first
	for (i = 0; i < 4; i++)
		frame_q.push_back(fcs[8*i +: 8]);
endtask

// low nibble then high nibble
task automatic send_byte(input mii_rx_pkg::byte_t b);
	@(posedge rx_clk);
	rx_dv <= 1'b1;
	rx_d  <= b[3:0];
	@(posedge rx_clk);
	rx_d  <= b[7:4];
endtask

// preamble, sfd and the first n bytes of frame_q, dv stays high
task automatic send_frame(input int pre_n, input int n);
	int i;
	for (i = 0; i < pre_n; i++)
		send_byte(8'h55);
	send_byte(8'hD5);
	for (i = 0; i < n && i < frame_q.size(); i++)
		send_byte(frame_q[i]);
endtask

task automatic end_frame();
	@(posedge rx_clk);
	rx_dv <= 1'b0;
	rx_d  <= 4'h0;
endtask

`endif

//--- bench/tb_rx_mii_udp.sv
`timescale 1ns/1ns

module tb_rx_mii_udp;

	localparam int DONE_TIMEOUT = 64;

	logic                  rx_clk;
	logic                  c_done;
	logic                  rx_dv;
	mii_rx_pkg::nibble_t   rx_d;
	mii_rx_pkg::buf_addr_t ram_ra;
	mii_rx_pkg::byte_t     ram_rd;
	logic                  frame_done;
	logic                  frame_good;
	logic                  crc_err;
	logic                  hdr_reject;
	mii_rx_pkg::len_t      payload_len;
	mii_rx_pkg::len_t      frame_seq;
	udp_frame_pkg::mac_t   peer_mac;
	udp_frame_pkg::ip_t    peer_ip;
	udp_frame_pkg::port_t  peer_port;

	int err_cnt;
	int check_cnt;
	int run_tests;
	int bad_tests;
	int start_errs;

	// peer fields of the last good frame
	udp_frame_pkg::mac_t  exp_mac;
	udp_frame_pkg::ip_t   exp_ip;
	udp_frame_pkg::port_t exp_port;

	`include "tb_frame_build.svh"

	rx_mii_udp i_rx_mii_udp (
		.rx_clk      (rx_clk),
		.c_done      (c_done),
		.rx_dv       (rx_dv),
		.rx_d        (rx_d),
		.ram_ra      (ram_ra),
		.ram_rd      (ram_rd),
		.frame_done  (frame_done),
		.frame_good  (frame_good),
		.crc_err     (crc_err),
		.hdr_reject  (hdr_reject),
		.payload_len (payload_len),
		.frame_seq   (frame_seq),
		.peer_mac    (peer_mac),
		.peer_ip     (peer_ip),
		.peer_port   (peer_port)
	);

	initial
		rx_clk = 1'b0;

	always #4 rx_clk = ~rx_clk;

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge rx_clk);
	endtask

	task automatic start_test();
		start_errs = err_cnt;
	endtask

	task automatic end_test(input string name);
		run_tests++;
		if (err_cnt == start_errs)
			$display("%s: ok", name);
		else
		begin
			bad_tests++;
			$display("%s: %0d errors", name, err_cnt - start_errs);
		end
	endtask

	// outputs are sampled just after the edge, before its updates land
	task automatic wait_done(input int limit, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit)
		begin
			@(posedge rx_clk);
			seen = frame_done;
			n++;
		end
	endtask

	task automatic deliver(input int pre_n, input string what, output bit seen);
		send_frame(pre_n, frame_q.size());
		end_frame();
		wait_done(DONE_TIMEOUT, seen);
		if (!seen)
		begin
			err_cnt++;
			$display("timeout: the %s frame gave no frame_done", what);
		end
	endtask

	task automatic check_status(input bit good, input bit crc, input bit rej);
		check("frame_good", frame_good, good);
		check("crc_err", crc_err, crc);
		check("hdr_reject", hdr_reject, rej);
	endtask

	task automatic check_peer();
		check("peer_mac", peer_mac, exp_mac);
		check("peer_ip", peer_ip, exp_ip);
		check("peer_port", peer_port, exp_port);
	endtask

	task automatic check_good(input udp_frame_pkg::mac_t mac, input udp_frame_pkg::ip_t ip,
		input udp_frame_pkg::port_t port, input int pay_n);
		check_status(1'b1, 1'b0, 1'b0);
		check("payload_len", payload_len, pay_n);
		check("frame_seq", frame_seq, {pay_q[1], pay_q[0]});
		exp_mac  = mac;
		exp_ip   = ip;
		exp_port = port;
		check_peer();
	endtask

	task automatic readback(input int n);
		int a;
		for (a = 0; a < n; a++)
		begin
			@(posedge rx_clk);
			ram_ra <= mii_rx_pkg::buf_addr_t'(a);
			// one edge for the address, one for the registered read
			@(posedge rx_clk);
			@(posedge rx_clk);
			check($sformatf("ram_rd[%0d]", a), ram_rd, pay_q[a]);
		end
	endtask

	task automatic good_frame_test();
		bit seen;
		start_test();
		build_frame(udp_frame_pkg::PEER_MAC_A, 16'h0800, 8'h11, 32'hC0A8_000A, 16'h1388, 40, 0);
		deliver(7, "good", seen);
		if (seen)
			check_good(udp_frame_pkg::PEER_MAC_A, 32'hC0A8_000A, 16'h1388, 40);
		idle(12);
		end_test("test 1 good frame");
	endtask

	task automatic readback_test();
		start_test();
		readback(40);
		end_test("test 2 payload readback");
	endtask

	task automatic bad_fcs_test();
		bit seen;
		start_test();
		build_frame(udp_frame_pkg::PEER_MAC_B, 16'h0800, 8'h11, 32'hC0A8_0014, 16'h2710, 24, 1);
		deliver(7, "corrupted fcs", seen);
		if (seen)
		begin
			check_status(1'b0, 1'b1, 1'b0);
			check_peer();
		end
		idle(12);
		end_test("test 3 corrupted fcs");
	endtask

	task automatic reject_case(input udp_frame_pkg::mac_t mac, input logic [15:0] eth_type,
		input logic [7:0] proto, input string what);
		bit seen;
		build_frame(mac, eth_type, proto, 32'hC0A8_001E, 16'h0BB8, 20, 0);
		deliver(7, what, seen);
		if (seen)
		begin
			check_status(1'b0, 1'b0, 1'b1);
			check_peer();
		end
		idle(12);
	endtask

	task automatic reject_test();
		start_test();
		reject_case(48'h11_22_33_44_55_66, 16'h0800, 8'h11, "unknown source mac");
		reject_case(udp_frame_pkg::PEER_MAC_A, 16'h0806, 8'h11, "arp ethertype");
		reject_case(udp_frame_pkg::PEER_MAC_B, 16'h0800, 8'h06, "tcp protocol");
		end_test("test 4 header rejects");
	endtask

	task automatic short_preamble_test();
		bit seen;
		start_test();
		build_frame(udp_frame_pkg::PEER_MAC_B, 16'h0800, 8'h11, 32'hC0A8_0028, 16'h4E20, 32, 0);
		send_frame(3, frame_q.size());
		end_frame();
		wait_done(DONE_TIMEOUT, seen);
		if (seen)
		begin
			err_cnt++;
			$display("a frame with a 3-byte preamble still produced frame_done");
		end
		idle(12);
		deliver(7, "good after short preamble", seen);
		if (seen)
			check_good(udp_frame_pkg::PEER_MAC_B, 32'hC0A8_0028, 16'h4E20, 32);
		idle(12);
		end_test("test 5 short preamble");
	endtask

	task automatic reset_test();
		bit seen;
		start_test();
		build_frame(udp_frame_pkg::PEER_MAC_A, 16'h0800, 8'h11, 32'hC0A8_0032, 16'h1F40, 40, 0);
		send_frame(7, 30);
		@(posedge rx_clk);
		c_done <= 1'b0;
		rx_dv  <= 1'b0;
		rx_d   <= 4'h0;
		idle(10);
		c_done <= 1'b1;
		// the cut frame must not be reported after release
		wait_done(12, seen);
		if (seen)
		begin
			err_cnt++;
			$display("frame_done pulsed after the reset although no frame was sent");
		end
		deliver(7, "good after reset", seen);
		if (seen)
			check_good(udp_frame_pkg::PEER_MAC_A, 32'hC0A8_0032, 16'h1F40, 40);
		readback(40);
		idle(12);
		end_test("test 6 reset in mid-frame");
	endtask

	initial
	begin
		int unsigned seed_val;
		rx_dv      = 1'b0;
		rx_d       = 4'h0;
		ram_ra     = '0;
		c_done     = 1'b0;
		err_cnt    = 0;
		check_cnt  = 0;
		run_tests  = 0;
		bad_tests  = 0;
		start_errs = 0;
		exp_mac    = '0;
		exp_ip     = '0;
		exp_port   = '0;
		seed_val   = $urandom(32'h4886_ed37);
		idle(10);
		c_done <= 1'b1;
		idle(12);
		good_frame_test();
		readback_test();
		bad_fcs_test();
		reject_test();
		short_preamble_test();
		reset_test();
		$display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
			run_tests, bad_tests, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- hw/rx_mii_udp.sv
`timescale 1ns/1ns

module rx_mii_udp (
	input  logic                  rx_clk,
	input  logic                  c_done,
	input  logic                  rx_dv,
	input  mii_rx_pkg::nibble_t   rx_d,
	input  mii_rx_pkg::buf_addr_t ram_ra,
	output mii_rx_pkg::byte_t     ram_rd,
	output logic                  frame_done,
	output logic                  frame_good,
	output logic                  crc_err,
	output logic                  hdr_reject,
	output mii_rx_pkg::len_t      payload_len,
	output mii_rx_pkg::len_t      frame_seq,
	output udp_frame_pkg::mac_t   peer_mac,
	output udp_frame_pkg::ip_t    peer_ip,
	output udp_frame_pkg::port_t  peer_port
);

	mii_rx_pkg::byte_t   byte_data;
	logic                byte_valid;
	logic                frame_active;
	logic                crc_clear;
	logic                crc_take;
	udp_frame_pkg::crc_t crc_value;
	logic                pay_start;
	logic                pay_take;

	mii_nibble_assembler i_mii_nibble_assembler (
		.rx_clk       (rx_clk),
		.c_done       (c_done),
		.rx_dv        (rx_dv),
		.rx_d         (rx_d),
		.byte_data    (byte_data),
		.byte_valid   (byte_valid),
		.frame_active (frame_active)
	);

	udp_header_parser i_udp_header_parser (
		.rx_clk       (rx_clk),
		.c_done       (c_done),
		.byte_data    (byte_data),
		.byte_valid   (byte_valid),
		.frame_active (frame_active),
		.crc_value    (crc_value),
		.crc_clear    (crc_clear),
		.crc_take     (crc_take),
		.pay_start    (pay_start),
		.pay_take     (pay_take),
		.frame_done   (frame_done),
		.frame_good   (frame_good),
		.crc_err      (crc_err),
		.hdr_reject   (hdr_reject),
		.payload_len  (payload_len),
		.peer_mac     (peer_mac),
		.peer_ip      (peer_ip),
		.peer_port    (peer_port)
	);

	crc32_d8 i_crc32_d8 (
		.rx_clk    (rx_clk),
		.c_done    (c_done),
		.crc_clear (crc_clear),
		.crc_take  (crc_take),
		.byte_data (byte_data),
		.crc_value (crc_value)
	);

	payload_buffer i_payload_buffer (
		.rx_clk    (rx_clk),
		.c_done    (c_done),
		.pay_start (pay_start),
		.pay_take  (pay_take),
		.byte_data (byte_data),
		.ram_ra    (ram_ra),
		.ram_rd    (ram_rd),
		.frame_seq (frame_seq)
	);

endmodule

//--- hw/udp_header_parser.sv
`timescale 1ns/1ns

module udp_header_parser (
	input  logic                 rx_clk,
	input  logic                 c_done,
	input  mii_rx_pkg::byte_t    byte_data,
	input  logic                 byte_valid,
	input  logic                 frame_active,
	input  udp_frame_pkg::crc_t  crc_value,
	output logic                 crc_clear,
	output logic                 crc_take,
	output logic                 pay_start,
	output logic                 pay_take,
	output logic                 frame_done,
	output logic                 frame_good,
	output logic                 crc_err,
	output logic                 hdr_reject,
	output mii_rx_pkg::len_t     payload_len,
	output udp_frame_pkg::mac_t  peer_mac,
	output udp_frame_pkg::ip_t   peer_ip,
	output udp_frame_pkg::port_t peer_port
);

	udp_frame_pkg::rx_state_t state;
	mii_rx_pkg::len_t         cnt;
	logic                     act_q;
	logic                     rej_pend;

	// captured header fields
	udp_frame_pkg::mac_t      src_mac;
	logic [15:0]              eth_type;
	logic [3:0]               ip_ver;
	logic [3:0]               ip_ihl;
	mii_rx_pkg::len_t         ip_total;
	logic [7:0]               ip_proto;
	udp_frame_pkg::ip_t       src_ip;
	udp_frame_pkg::port_t     src_port;
	udp_frame_pkg::crc_t      fcs;

	mii_rx_pkg::len_t         pay_len;
	logic                     eth_ok;
	logic                     ip_ok;
	logic                     fcs_ok;

	assign pay_len = ip_total -
		mii_rx_pkg::len_t'(udp_frame_pkg::IP_HDR_BYTES + udp_frame_pkg::UDP_HDR_BYTES);

	assign eth_ok = (eth_type == udp_frame_pkg::ETH_TYPE_IPV4) &&
		(src_mac == udp_frame_pkg::PEER_MAC_A || src_mac == udp_frame_pkg::PEER_MAC_B);

	assign ip_ok = (ip_ver == udp_frame_pkg::IP_VER) &&
		(ip_ihl == udp_frame_pkg::IP_HDR_LEN) && (ip_proto == udp_frame_pkg::IP_PROTO_UDP);

	assign fcs_ok = (cnt == mii_rx_pkg::len_t'(udp_frame_pkg::FCS_BYTES)) && (fcs == crc_value);

	// crc runs from the destination mac to the last payload byte
	assign crc_take = byte_valid && (state inside {udp_frame_pkg::ETH_HDR, udp_frame_pkg::IP_HDR,
		udp_frame_pkg::UDP_HDR, udp_frame_pkg::PAYLOAD});
	assign pay_take = byte_valid && (state == udp_frame_pkg::PAYLOAD);

	always_ff @(posedge rx_clk or negedge c_done)
	begin
		if (!c_done)
		begin
			state     <= udp_frame_pkg::IDLE;
			cnt       <= '0;
			act_q     <= 1'b0;
			rej_pend  <= 1'b0;
			crc_clear <= 1'b0;
			pay_start <= 1'b0;
		end
		else
		begin
			act_q     <= frame_active;
			crc_clear <= 1'b0;
			pay_start <= 1'b0;
			case (state)
			udp_frame_pkg::IDLE:
			begin
				cnt <= '0;
				// a rejected frame is reported once its dv drops
				if (rej_pend)
				begin
					if (!frame_active)
						rej_pend <= 1'b0;
				end
				else if (frame_active && !act_q)
				begin
					state     <= udp_frame_pkg::PREAMBLE;
					crc_clear <= 1'b1;
				end
			end
			udp_frame_pkg::PREAMBLE:
			begin
				if (!frame_active)
					state <= udp_frame_pkg::IDLE;
				else if (byte_valid)
				begin
					if (byte_data == udp_frame_pkg::PREAMBLE_BYTE)
					begin
						if (cnt == mii_rx_pkg::len_t'(udp_frame_pkg::PREAMBLE_MAX - 1))
							state <= udp_frame_pkg::IDLE;
						else
							cnt <= cnt + 1'b1;
					end
					else if (byte_data == udp_frame_pkg::SFD_BYTE &&
						cnt >= mii_rx_pkg::len_t'(udp_frame_pkg::PREAMBLE_MIN))
					begin
						state <= udp_frame_pkg::ETH_HDR;
						cnt   <= '0;
					end
					else
						state <= udp_frame_pkg::IDLE;
				end
			end
			udp_frame_pkg::ETH_HDR:
			begin
				if (!frame_active)
					state <= udp_frame_pkg::IDLE;
				else if (byte_valid)
				begin
					if (cnt == mii_rx_pkg::len_t'(udp_frame_pkg::ETH_HDR_BYTES - 1))
					begin
						state <= udp_frame_pkg::IP_HDR;
						cnt   <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
			end
			udp_frame_pkg::IP_HDR:
			begin
				if (!frame_active)
					state <= udp_frame_pkg::IDLE;
				else if (byte_valid)
				begin
					// ethernet filter is judged on the third ip byte
					if (cnt == 16'd2 && !eth_ok)
					begin
						state    <= udp_frame_pkg::IDLE;
						rej_pend <= 1'b1;
					end
					else if (cnt == mii_rx_pkg::len_t'(udp_frame_pkg::IP_HDR_BYTES - 1))
					begin
						state <= udp_frame_pkg::UDP_HDR;
						cnt   <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
			end
			udp_frame_pkg::UDP_HDR:
			begin
				if (!frame_active)
					state <= udp_frame_pkg::IDLE;
				else if (byte_valid)
				begin
					if (cnt == 16'd2 && !ip_ok)
					begin
						state    <= udp_frame_pkg::IDLE;
						rej_pend <= 1'b1;
					end
					else if (cnt == mii_rx_pkg::len_t'(udp_frame_pkg::UDP_HDR_BYTES - 1))
					begin
						cnt <= '0;
						if (pay_len == '0)
							state <= udp_frame_pkg::FCS;
						else
						begin
							state     <= udp_frame_pkg::PAYLOAD;
							pay_start <= 1'b1;
						end
					end
					else
						cnt <= cnt + 1'b1;
				end
			end
			udp_frame_pkg::PAYLOAD:
			begin
				if (!frame_active)
					state <= udp_frame_pkg::IDLE;
				else if (byte_valid)
				begin
					if (cnt == pay_len - 1'b1)
					begin
						state <= udp_frame_pkg::FCS;
						cnt   <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
			end
			udp_frame_pkg::FCS:
			begin
				if (!frame_active)
					state <= udp_frame_pkg::CHECK;
				else if (byte_valid && cnt < mii_rx_pkg::len_t'(udp_frame_pkg::FCS_BYTES))
					cnt <= cnt + 1'b1;
			end
			default:
			begin
				state <= udp_frame_pkg::IDLE;
				cnt   <= '0;
			end
			endcase
		end
	end

	// field capture, fields are shifted in msb first
	always_ff @(posedge rx_clk)
	begin
		if (byte_valid)
		begin
			case (state)
			udp_frame_pkg::ETH_HDR:
			begin
				if (cnt >= 16'd6 && cnt < 16'd12)
					src_mac <= {src_mac[39:0], byte_data};
				else if (cnt >= 16'd12)
					eth_type <= {eth_type[7:0], byte_data};
			end
			udp_frame_pkg::IP_HDR:
			begin
				if (cnt == 16'd0)
					{ip_ver, ip_ihl} <= byte_data;
				else if (cnt == 16'd2 || cnt == 16'd3)
					ip_total <= {ip_total[7:0], byte_data};
				else if (cnt == 16'd9)
					ip_proto <= byte_data;
				else if (cnt >= 16'd12 && cnt < 16'd16)
					src_ip <= {src_ip[23:0], byte_data};
			end
			udp_frame_pkg::UDP_HDR:
			begin
				if (cnt < 16'd2)
					src_port <= {src_port[7:0], byte_data};
			end
			udp_frame_pkg::FCS:
			begin
				// fcs arrives least significant byte first
				if (cnt < mii_rx_pkg::len_t'(udp_frame_pkg::FCS_BYTES))
					fcs <= {byte_data, fcs[31:8]};
			end
			default:
			begin
			end
			endcase
		end
	end

	// frame status and peer fields
	always_ff @(posedge rx_clk or negedge c_done)
	begin
		if (!c_done)
		begin
			frame_done  <= 1'b0;
			frame_good  <= 1'b0;
			crc_err     <= 1'b0;
			hdr_reject  <= 1'b0;
			payload_len <= '0;
			peer_mac    <= '0;
			peer_ip     <= '0;
			peer_port   <= '0;
		end
		else
		begin
			frame_done <= 1'b0;
			if (state == udp_frame_pkg::CHECK)
			begin
				frame_done  <= 1'b1;
				frame_good  <= fcs_ok;
				crc_err     <= !fcs_ok;
				hdr_reject  <= 1'b0;
				payload_len <= pay_len;
				if (fcs_ok)
				begin
					peer_mac  <= src_mac;
					peer_ip   <= src_ip;
					peer_port <= src_port;
				end
			end
			else if (state == udp_frame_pkg::IDLE && rej_pend && !frame_active)
			begin
				frame_done <= 1'b1;
				frame_good <= 1'b0;
				crc_err    <= 1'b0;
				hdr_reject <= 1'b1;
			end
		end
	end

endmodule

//--- hw/payload_buffer.sv
`timescale 1ns/1ns

module payload_buffer (
	input  logic                  rx_clk,
	input  logic                  c_done,
	input  logic                  pay_start,
	input  logic                  pay_take,
	input  mii_rx_pkg::byte_t     byte_data,
	input  mii_rx_pkg::buf_addr_t ram_ra,
	output mii_rx_pkg::byte_t     ram_rd,
	output mii_rx_pkg::len_t      frame_seq
);

	mii_rx_pkg::byte_t     mem [mii_rx_pkg::BUF_DEPTH];
	mii_rx_pkg::buf_addr_t wr_addr;
	logic                  full;
	logic                  wr_en;

	// writes stop once the last entry is used
	assign wr_en = pay_take && !full;

	always_ff @(posedge rx_clk or negedge c_done)
	begin
		if (!c_done)
		begin
			wr_addr   <= '0;
			full      <= 1'b0;
			frame_seq <= '0;
		end
		else if (pay_start)
		begin
			wr_addr <= '0;
			full    <= 1'b0;
		end
		else if (wr_en)
		begin
			// sequence number, low byte first
			if (wr_addr == mii_rx_pkg::buf_addr_t'(0))
				frame_seq[7:0] <= byte_data;
			if (wr_addr == mii_rx_pkg::buf_addr_t'(1))
				frame_seq[15:8] <= byte_data;
			if (wr_addr == mii_rx_pkg::buf_addr_t'(mii_rx_pkg::BUF_DEPTH - 1))
				full <= 1'b1;
			else
				wr_addr <= wr_addr + 1'b1;
		end
	end

	// storage with a registered read port
	always_ff @(posedge rx_clk)
	begin
		if (wr_en)
			mem[wr_addr] <= byte_data;
		ram_rd <= mem[ram_ra];
	end

endmodule

//--- hw/crc32_d8.sv
`timescale 1ns/1ns

module crc32_d8 (
	input  logic                rx_clk,
	input  logic                c_done,
	input  logic                crc_clear,
	input  logic                crc_take,
	input  mii_rx_pkg::byte_t   byte_data,
	output udp_frame_pkg::crc_t crc_value
);

	udp_frame_pkg::crc_t crc_reg;

	// one byte through the reflected crc, lsb first
	function automatic udp_frame_pkg::crc_t crc_next(udp_frame_pkg::crc_t crc_in,
		mii_rx_pkg::byte_t data);
		udp_frame_pkg::crc_t poly_r;
		udp_frame_pkg::crc_t r;
		poly_r = {<<{udp_frame_pkg::CRC_POLY}};
		r = crc_in ^ {24'h0, data};
		for (int i = 0; i < 8; i++)
		begin
			if (r[0])
				r = (r >> 1) ^ poly_r;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	always_ff @(posedge rx_clk or negedge c_done)
	begin
		if (!c_done)
			crc_reg <= udp_frame_pkg::CRC_INIT;
		else if (crc_clear)
			crc_reg <= udp_frame_pkg::CRC_INIT;
		else if (crc_take)
			crc_reg <= crc_next(crc_reg, byte_data);
	end

	// inverted register matches the fcs as received
	assign crc_value = ~crc_reg;

endmodule

//--- hw/mii_nibble_assembler.sv
`timescale 1ns/1ns

module mii_nibble_assembler (
	input  logic                rx_clk,
	input  logic                c_done,
	input  logic                rx_dv,
	input  mii_rx_pkg::nibble_t rx_d,
	output mii_rx_pkg::byte_t   byte_data,
	output logic                byte_valid,
	output logic                frame_active
);

	logic                dv_d1;
	logic                dv_d2;
	mii_rx_pkg::nibble_t d_d1;
	mii_rx_pkg::nibble_t d_d2;
	mii_rx_pkg::nibble_t low_nib;
	logic                phase;

	// two register stages on the mii inputs
	always_ff @(posedge rx_clk or negedge c_done)
	begin
		if (!c_done)
		begin
			dv_d1 <= 1'b0;
			dv_d2 <= 1'b0;
		end
		else
		begin
			dv_d1 <= rx_dv;
			dv_d2 <= dv_d1;
		end
	end

	always_ff @(posedge rx_clk)
	begin
		d_d1 <= rx_d;
		d_d2 <= d_d1;
	end

	// phase restarts at 0 whenever dv is low
	always_ff @(posedge rx_clk or negedge c_done)
	begin
		if (!c_done)
		begin
			phase        <= 1'b0;
			byte_valid   <= 1'b0;
			frame_active <= 1'b0;
		end
		else
		begin
			phase        <= dv_d2 & ~phase;
			byte_valid   <= dv_d2 & phase;
			frame_active <= dv_d2;
		end
	end

	// low nibble first, byte completes on the high nibble
	always_ff @(posedge rx_clk)
	begin
		if (dv_d2 && !phase)
			low_nib <= d_d2;
		if (dv_d2 && phase)
			byte_data <= {d_d2, low_nib};
	end

endmodule

//--- hw/udp_frame_pkg.sv
package udp_frame_pkg;

	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip_t;
	typedef logic [15:0] port_t;
	typedef logic [31:0] crc_t;

	// preamble and start-of-frame delimiter
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE      = 8'hD5;
	localparam int         PREAMBLE_MIN  = 6;
	localparam int         PREAMBLE_MAX  = 8;

	// header filter
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [3:0]  IP_VER        = 4'd4;
	localparam logic [3:0]  IP_HDR_LEN    = 4'd5;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
	localparam mac_t        PEER_MAC_A    = 48'hAA_BB_CC_DD_EE_FF;
	localparam mac_t        PEER_MAC_B    = 48'h77_88_77_88_77_88;

	// section sizes in bytes
	localparam int ETH_HDR_BYTES = 14;
	localparam int IP_HDR_BYTES  = 20;
	localparam int UDP_HDR_BYTES = 8;
	localparam int FCS_BYTES     = 4;

	// ethernet crc-32, used bit-reflected
	localparam crc_t CRC_POLY = 32'h04C1_1DB7;
	localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

	typedef enum logic [2:0] {
		IDLE,
		PREAMBLE,
		ETH_HDR,
		IP_HDR,
		UDP_HDR,
		PAYLOAD,
		FCS,
		CHECK
	} rx_state_t;

endpackage

//--- hw/mii_rx_pkg.sv
package mii_rx_pkg;

	// payload buffer geometry, one 1472-byte payload fits
	localparam int BUF_ADDR_W = 11;
	localparam int BUF_DEPTH  = 2048;

	// mii side
	typedef logic [3:0] nibble_t;

	// byte stream after nibble pairing
	typedef logic [7:0] byte_t;

	typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

	// byte counts, lengths and the sequence number
	typedef logic [15:0] len_t;

endpackage
